// ==== bp_assertions.sv ====
// Checker bound to branch_predictor_top
// Shadows the IF/ID record from the top's ports and checks the reset state
// and the redirect rules with concurrent assertions

`timescale 1ns/1ps

module bp_assertions (
  input logic              clk,
  input logic              rst,
  input logic              fetch_valid,
  input bp_types_pkg::pc_t fetch_pc,
  input logic              resolve_valid,
  input logic              actual_taken,
  input bp_types_pkg::pc_t actual_target,
  input logic              pred_taken,
  input bp_types_pkg::pc_t pred_next_pc,
  input logic              redirect_valid,
  input bp_types_pkg::pc_t redirect_pc
);

  //////////////////////////////
  // Shadow of the last fetch
  //////////////////////////////
  logic                          shd_valid;      // Shadow holds a live fetch
  bp_types_pkg::pc_t             shd_pc;         // Fetched PC
  logic                          shd_taken;      // Direction seen at fetch
  bp_types_pkg::pc_t             shd_next_pc;    // Next PC seen at fetch
  logic                          btb_empty;      // No taken branch trained yet
  bp_state_pkg::redirect_cause_e exp_cause;      // Cause the rules call for

  int reset_redirect_fails = 0;
  int reset_lookup_fails   = 0;
  int redirect_match_fails = 0;
  int redirect_pc_fails    = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      shd_valid <= 1'b0;
      btb_empty <= 1'b1;
    end else begin
      if (redirect_valid) begin
        shd_valid <= 1'b0;                          // Flush wins over a new fetch
      end else if (fetch_valid) begin
        shd_valid <= 1'b1;
      end
      if (shd_valid && resolve_valid && actual_taken) begin
        btb_empty <= 1'b0;                          // First BTB write lands here
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      shd_pc      <= fetch_pc;
      shd_taken   <= pred_taken;
      shd_next_pc <= pred_next_pc;
    end
  end

  always_comb begin
    exp_cause = bp_state_pkg::none;
    if (shd_valid && resolve_valid) begin
      if (shd_taken != actual_taken) begin
        exp_cause = bp_state_pkg::dir_wrong;
      end else if (actual_taken && (shd_next_pc != actual_target)) begin
        exp_cause = bp_state_pkg::target_wrong;
      end
    end
  end

  //////////////////////////////
  // Reset state
  //////////////////////////////
  a_reset_redirect: assert property (@(posedge clk) rst |=> !redirect_valid)
    else begin
      reset_redirect_fails = reset_redirect_fails + 1;
      $error("redirect_valid high in the cycle after reset");
    end

  // Empty tables always fall through to PC plus 2
  a_reset_lookup: assert property (@(posedge clk) disable iff (rst)
    btb_empty |-> (!pred_taken && (pred_next_pc == fetch_pc + 16'd2)))
    else begin
      reset_lookup_fails = reset_lookup_fails + 1;
      $error("Lookup before any taken branch did not fall through, pc %h next %h",
             fetch_pc, pred_next_pc);
    end

  //////////////////////////////
  // Redirect rules
  //////////////////////////////
  a_redirect_match: assert property (@(posedge clk) disable iff (rst)
    redirect_valid == (exp_cause != bp_state_pkg::none))
    else begin
      redirect_match_fails = redirect_match_fails + 1;
      $error("redirect_valid %b disagrees with cause %0d", redirect_valid, exp_cause);
    end

  a_redirect_pc: assert property (@(posedge clk) disable iff (rst)
    redirect_valid |-> (redirect_pc == (actual_taken ? actual_target : shd_pc + 16'd2)))
    else begin
      redirect_pc_fails = redirect_pc_fails + 1;
      $error("redirect_pc %h is neither the target nor the fall-through", redirect_pc);
    end

endmodule

bind branch_predictor_top bp_assertions u_assert (
  .clk            (clk),
  .rst            (rst),
  .fetch_valid    (fetch_valid),
  .fetch_pc       (fetch_pc),
  .resolve_valid  (resolve_valid),
  .actual_taken   (actual_taken),
  .actual_target  (actual_target),
  .pred_taken     (pred_taken),
  .pred_next_pc   (pred_next_pc),
  .redirect_valid (redirect_valid),
  .redirect_pc    (redirect_pc)
);

// ==== bp_defs.svh ====
// Sizing macros for the branch predictor tables
// Include wherever PC fields or table depth are needed

`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Instruction address width
`define BP_PC_W    16

// Index comes from PC[3:1] since instructions are halfword aligned
`define BP_IDX_W   3

// Tag is the rest of the PC above the index, PC[15:4]
`define BP_TAG_W   12

// Direct mapped table depth
`define BP_ENTRIES 8

`endif

// ==== bp_lookup.sv ====
// Fetch side of the branch predictor
// Splits fetch_pc, checks both table tags and picks the next fetch PC
// Purely combinational so the prediction is ready in the fetch cycle

`timescale 1ns/1ps

`include "bp_defs.svh"

module bp_lookup (
  input  bp_types_pkg::pc_t  fetch_pc,       // PC being fetched
  output bp_types_pkg::idx_t rd_idx,         // Row select to tables
  input  logic               bht_rd_valid,   // BHT row valid
  input  logic               btb_rd_valid,   // BTB row valid
  input  bp_types_pkg::tag_t bht_rd_tag,     // BHT row tag
  input  bp_types_pkg::tag_t btb_rd_tag,     // BTB row tag
  input  bp_types_pkg::ctr_t bht_rd_ctr,     // BHT row counter
  input  bp_types_pkg::pc_t  btb_rd_target,  // BTB row target
  output logic               pred_taken,     // Redirect fetch to target
  output bp_types_pkg::pc_t  pred_next_pc,   // Next PC to fetch
  output bp_types_pkg::ctr_t pred_ctr        // Counter seen, strong_nt on miss
);

  bp_types_pkg::tag_t fetch_tag;  // Upper PC bits of this fetch
  logic               bht_hit;    // BHT row belongs to this PC
  logic               btb_hit;    // BTB row belongs to this PC
  logic               dir_taken;  // Counter says taken

  //////////////////////////////
  // PC split
  //////////////////////////////
  assign rd_idx    = fetch_pc[`BP_IDX_W:1];                  // Bit 0 is always zero
  assign fetch_tag = fetch_pc[`BP_PC_W-1:`BP_PC_W-`BP_TAG_W];

  //////////////////////////////
  // Tag compare
  //////////////////////////////
  assign bht_hit = bht_rd_valid && (bht_rd_tag == fetch_tag);
  assign btb_hit = btb_rd_valid && (btb_rd_tag == fetch_tag);

  //////////////////////////////
  // Direction and next PC
  //////////////////////////////
  assign dir_taken = bht_hit && bht_rd_ctr[1];   // Upper bit set in both taken states

  // Without a target we can't go anywhere but the fall-through
  assign pred_taken   = dir_taken && btb_hit;
  assign pred_next_pc = pred_taken ? btb_rd_target : fetch_pc + bp_types_pkg::pc_t'(2);

  // Unknown branches start from the bottom of the counter
  assign pred_ctr = bht_hit ? bht_rd_ctr : bp_types_pkg::ctr_t'(bp_state_pkg::strong_nt);

endmodule

// ==== bp_resolve.sv ====
// Resolve side of the branch predictor
// Keeps the IF/ID prediction record, trains the tables when decode
// resolves the branch and raises a redirect on a misprediction

`timescale 1ns/1ps

`include "bp_defs.svh"

module bp_resolve (
  input  logic               clk,            // System clock
  input  logic               rst,            // Sync reset, active high
  input  logic               fetch_valid,    // Fetch slot holds an instruction
  input  bp_types_pkg::pc_t  fetch_pc,       // PC fetched this cycle
  input  logic               pred_taken,     // Prediction for fetch_pc
  input  bp_types_pkg::pc_t  pred_next_pc,   // Predicted next PC
  input  bp_types_pkg::ctr_t pred_ctr,       // Counter behind the prediction
  input  logic               resolve_valid,  // Decode resolved a branch
  input  logic               actual_taken,   // Real direction
  input  bp_types_pkg::pc_t  actual_target,  // Real target when taken
  output bp_types_pkg::idx_t wr_idx,         // Table row to train
  output bp_types_pkg::tag_t wr_tag,         // Tag of resolved branch
  output logic               bht_wr_en,      // Train BHT
  output logic               btb_wr_en,      // Train BTB
  output bp_types_pkg::ctr_t bht_wr_ctr,     // Updated counter
  output bp_types_pkg::pc_t  btb_wr_target,  // Target to remember
  output logic               redirect_valid, // Fetch went the wrong way
  output bp_types_pkg::pc_t  redirect_pc     // Where fetch should go
);

  //////////////////////////////
  // IF/ID prediction record
  //////////////////////////////
  logic                          rec_valid;      // Record holds a live instruction
  bp_types_pkg::pc_t             rec_pc;         // Its PC
  logic                          rec_taken;      // What we guessed
  bp_types_pkg::pc_t             rec_next_pc;    // Where we sent fetch
  bp_types_pkg::ctr_t            rec_ctr;        // Counter at lookup time

  logic                          res_fire;       // Resolve for a live record
  bp_state_pkg::ctr_state_e      ctr_next;       // Counter after training
  bp_state_pkg::redirect_cause_e redirect_cause; // Misprediction class

  always_ff @(posedge clk) begin
    if (rst) begin
      rec_valid <= 1'b0;
    end else if (redirect_valid) begin
      rec_valid <= 1'b0;                 // Wrong-path fetch is dropped
    end else if (fetch_valid) begin
      rec_valid <= 1'b1;
    end
  end

  // Payload follows rec_valid, no reset needed
  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      rec_pc      <= fetch_pc;
      rec_taken   <= pred_taken;
      rec_next_pc <= pred_next_pc;
      rec_ctr     <= pred_ctr;
    end
  end

  assign res_fire = resolve_valid && rec_valid;  // Stale resolves are ignored

  //////////////////////////////
  // Counter next state
  //////////////////////////////
  always_comb begin
    case (bp_state_pkg::ctr_state_e'(rec_ctr))
      bp_state_pkg::strong_nt: ctr_next = actual_taken ? bp_state_pkg::weak_nt
                                                       : bp_state_pkg::strong_nt;
      bp_state_pkg::weak_nt:   ctr_next = actual_taken ? bp_state_pkg::weak_t
                                                       : bp_state_pkg::strong_nt;
      bp_state_pkg::weak_t:    ctr_next = actual_taken ? bp_state_pkg::strong_t
                                                       : bp_state_pkg::weak_nt;
      default:                 ctr_next = actual_taken ? bp_state_pkg::strong_t
                                                       : bp_state_pkg::weak_t;
    endcase
  end

  //////////////////////////////
  // Misprediction check
  //////////////////////////////
  always_comb begin
    redirect_cause = bp_state_pkg::none;
    if (res_fire) begin
      if (rec_taken != actual_taken) begin
        redirect_cause = bp_state_pkg::dir_wrong;
      end else if (actual_taken && (rec_next_pc != actual_target)) begin
        redirect_cause = bp_state_pkg::target_wrong;  // Stale or aliased BTB entry
      end
    end
  end

  assign redirect_valid = (redirect_cause != bp_state_pkg::none);
  assign redirect_pc    = actual_taken ? actual_target
                                       : rec_pc + bp_types_pkg::pc_t'(2);

  //////////////////////////////
  // Table training
  //////////////////////////////
  assign wr_idx        = rec_pc[`BP_IDX_W:1];
  assign wr_tag        = rec_pc[`BP_PC_W-1:`BP_PC_W-`BP_TAG_W];
  assign bht_wr_en     = res_fire;                 // Every resolved branch
  assign btb_wr_en     = res_fire && actual_taken; // Taken ones only
  assign bht_wr_ctr    = bp_types_pkg::ctr_t'(ctr_next);
  assign btb_wr_target = actual_target;

endmodule

// ==== bp_state_pkg.sv ====
// Enumerations for the predictor state machines
// Refer to them as bp_state_pkg::name

package bp_state_pkg;

  //////////////////////////////
  // 2-bit saturating counter
  //////////////////////////////
  typedef enum logic [1:0] {
    strong_nt = 2'd0,  // Predict not taken, needs two taken to flip
    weak_nt   = 2'd1,  // Predict not taken
    weak_t    = 2'd2,  // Predict taken
    strong_t  = 2'd3   // Predict taken, needs two not taken to flip
  } ctr_state_e;

  //////////////////////////////
  // Why fetch gets redirected
  //////////////////////////////
  typedef enum logic [1:0] {
    none         = 2'd0,  // Prediction was right
    dir_wrong    = 2'd1,  // Taken/not taken guessed wrong
    target_wrong = 2'd2   // Taken as guessed, but to another address
  } redirect_cause_e;

endpackage

// ==== bp_tables.sv ====
// BHT and BTB storage for the branch predictor
// One read port driven by fetch, one write port driven by resolve
// Reads are combinational, writes land on the clock edge

`timescale 1ns/1ps

`include "bp_defs.svh"

module bp_tables (
  input  logic               clk,            // System clock
  input  logic               rst,            // Sync reset, active high

  // Fetch side read port
  input  bp_types_pkg::idx_t rd_idx,         // Row to read
  output logic               bht_rd_valid,   // BHT row holds an entry
  output logic               btb_rd_valid,   // BTB row holds an entry
  output bp_types_pkg::tag_t bht_rd_tag,     // Tag stored in BHT row
  output bp_types_pkg::tag_t btb_rd_tag,     // Tag stored in BTB row
  output bp_types_pkg::ctr_t bht_rd_ctr,     // Counter stored in BHT row
  output bp_types_pkg::pc_t  btb_rd_target,  // Target stored in BTB row

  // Resolve side write port
  input  bp_types_pkg::idx_t wr_idx,         // Row to write
  input  bp_types_pkg::tag_t wr_tag,         // Tag for both tables
  input  logic               bht_wr_en,      // Update BHT row
  input  logic               btb_wr_en,      // Update BTB row
  input  bp_types_pkg::ctr_t bht_wr_ctr,     // New counter value
  input  bp_types_pkg::pc_t  btb_wr_target   // New target address
);

  //////////////////////////////
  // Storage
  //////////////////////////////
  // Branch history table
  bp_types_pkg::tag_t     bht_tag [`BP_ENTRIES];  // Tag per row
  bp_types_pkg::ctr_t     bht_ctr [`BP_ENTRIES];  // Counter per row
  logic [`BP_ENTRIES-1:0] bht_vld;                // Row written since reset

  // Branch target buffer
  bp_types_pkg::tag_t     btb_tag [`BP_ENTRIES];  // Tag per row
  bp_types_pkg::pc_t      btb_tgt [`BP_ENTRIES];  // Target per row
  logic [`BP_ENTRIES-1:0] btb_vld;                // Row written since reset

  //////////////////////////////
  // Valid bits
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      bht_vld <= '0;                   // Tables start empty
      btb_vld <= '0;
    end else begin
      if (bht_wr_en) begin
        bht_vld[wr_idx] <= 1'b1;       // Row now owned by wr_tag
      end
      if (btb_wr_en) begin
        btb_vld[wr_idx] <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // BHT payload
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (bht_wr_en) begin
      bht_tag[wr_idx] <= wr_tag;       // Replaces any aliasing branch
      bht_ctr[wr_idx] <= bht_wr_ctr;   // Already saturated by resolve
    end
  end

  //////////////////////////////
  // BTB payload
  //////////////////////////////
  // Only taken branches have a target worth keeping
  always_ff @(posedge clk) begin
    if (btb_wr_en) begin
      btb_tag[wr_idx] <= wr_tag;
      btb_tgt[wr_idx] <= btb_wr_target;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////
  // No write bypass, a same-cycle write shows up next cycle
  assign bht_rd_valid  = bht_vld[rd_idx];
  assign bht_rd_tag    = bht_tag[rd_idx];
  assign bht_rd_ctr    = bht_ctr[rd_idx];

  assign btb_rd_valid  = btb_vld[rd_idx];
  assign btb_rd_tag    = btb_tag[rd_idx];
  assign btb_rd_target = btb_tgt[rd_idx];

endmodule

// ==== bp_types_pkg.sv ====
// Vector types shared by the predictor blocks
// Refer to them as bp_types_pkg::name

`include "bp_defs.svh"

package bp_types_pkg;

  //////////////////////////////
  // Address fields
  //////////////////////////////
  typedef logic [`BP_PC_W-1:0]  pc_t;   // Full instruction address
  typedef logic [`BP_TAG_W-1:0] tag_t;  // Upper PC bits kept per entry
  typedef logic [`BP_IDX_W-1:0] idx_t;  // Table row select

  //////////////////////////////
  // Table payload
  //////////////////////////////
  // Counter as it sits in the BHT, decoded through bp_state_pkg
  typedef logic [1:0] ctr_t;

endpackage

// ==== branch_predictor_top.f ====
+incdir+.
bp_types_pkg.sv
bp_state_pkg.sv
bp_tables.sv
bp_lookup.sv
bp_resolve.sv
branch_predictor_top.sv
bp_assertions.sv
tb_branch_predictor.sv

// ==== branch_predictor_top.sv ====
// Top level of the dynamic branch predictor
// Fetch drives fetch_pc and reads the prediction in the same cycle
// Decode drives the resolve inputs one cycle later for the same PC

`timescale 1ns/1ps

module branch_predictor_top (
  input  logic              clk,            // System clock
  input  logic              rst,            // Sync reset, active high
  input  logic              fetch_valid,    // Fetch slot valid
  input  bp_types_pkg::pc_t fetch_pc,       // PC being fetched
  input  logic              resolve_valid,  // Decode resolved a branch
  input  logic              actual_taken,   // Real direction
  input  bp_types_pkg::pc_t actual_target,  // Real target
  output logic              pred_taken,     // Predicted taken
  output bp_types_pkg::pc_t pred_next_pc,   // Predicted next PC
  output logic              redirect_valid, // Misprediction flush
  output bp_types_pkg::pc_t redirect_pc     // Corrected PC
);

  // Table read port
  bp_types_pkg::idx_t rd_idx;
  logic               bht_rd_valid;
  logic               btb_rd_valid;
  bp_types_pkg::tag_t bht_rd_tag;
  bp_types_pkg::tag_t btb_rd_tag;
  bp_types_pkg::ctr_t bht_rd_ctr;
  bp_types_pkg::pc_t  btb_rd_target;
  bp_types_pkg::ctr_t pred_ctr;      // Into the IF/ID record

  // Table write port
  bp_types_pkg::idx_t wr_idx;
  bp_types_pkg::tag_t wr_tag;
  logic               bht_wr_en;
  logic               btb_wr_en;
  bp_types_pkg::ctr_t bht_wr_ctr;
  bp_types_pkg::pc_t  btb_wr_target;

  //////////////////////////////
  // Fetch lookup
  //////////////////////////////
  bp_lookup u_lookup (
    .fetch_pc      (fetch_pc),
    .rd_idx        (rd_idx),
    .bht_rd_valid  (bht_rd_valid),
    .btb_rd_valid  (btb_rd_valid),
    .bht_rd_tag    (bht_rd_tag),
    .btb_rd_tag    (btb_rd_tag),
    .bht_rd_ctr    (bht_rd_ctr),
    .btb_rd_target (btb_rd_target),
    .pred_taken    (pred_taken),
    .pred_next_pc  (pred_next_pc),
    .pred_ctr      (pred_ctr)
  );

  //////////////////////////////
  // Record and resolve
  //////////////////////////////
  bp_resolve u_resolve (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .pred_taken     (pred_taken),
    .pred_next_pc   (pred_next_pc),
    .pred_ctr       (pred_ctr),
    .resolve_valid  (resolve_valid),
    .actual_taken   (actual_taken),
    .actual_target  (actual_target),
    .wr_idx         (wr_idx),
    .wr_tag         (wr_tag),
    .bht_wr_en      (bht_wr_en),
    .btb_wr_en      (btb_wr_en),
    .bht_wr_ctr     (bht_wr_ctr),
    .btb_wr_target  (btb_wr_target),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  //////////////////////////////
  // BHT and BTB
  //////////////////////////////
  bp_tables u_tables (
    .clk           (clk),
    .rst           (rst),
    .rd_idx        (rd_idx),
    .bht_rd_valid  (bht_rd_valid),
    .btb_rd_valid  (btb_rd_valid),
    .bht_rd_tag    (bht_rd_tag),
    .btb_rd_tag    (btb_rd_tag),
    .bht_rd_ctr    (bht_rd_ctr),
    .btb_rd_target (btb_rd_target),
    .wr_idx        (wr_idx),
    .wr_tag        (wr_tag),
    .bht_wr_en     (bht_wr_en),
    .btb_wr_en     (btb_wr_en),
    .bht_wr_ctr    (bht_wr_ctr),
    .btb_wr_target (btb_wr_target)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator.
# Exits non-zero when the build fails, the simulator fails or the pass line is missing.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  -f branch_predictor_top.f \
  --top-module tb_branch_predictor \
  -o tb_branch_predictor > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/tb_branch_predictor +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$SIM_LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1

// ==== tb_branch_predictor.sv ====
// Testbench for the branch predictor
// Directed training, hysteresis, aliasing and retargeting checks,
// then random fetch and resolve traffic for the bound checker

`timescale 1ns/1ps

module tb_branch_predictor;

  localparam int CLK_PERIOD      = 40;
  localparam int N_RANDOM        = 200;
  localparam int DIRECTED_CYCLES = 50;                       // Reset plus directed phases
  localparam int TOTAL_CYCLES    = DIRECTED_CYCLES + 2 * N_RANDOM + 10;
  localparam int WATCHDOG_NS     = TOTAL_CYCLES * CLK_PERIOD + 2000;

  localparam bp_types_pkg::pc_t PC_A  = 16'h1234;           // Index 2, tag 123
  localparam bp_types_pkg::pc_t PC_B  = 16'h5674;           // Same index, tag 567
  localparam bp_types_pkg::pc_t TGT_1 = 16'h2000;
  localparam bp_types_pkg::pc_t TGT_2 = 16'h2468;

  logic              clk;
  logic              rst;
  logic              fetch_valid;
  bp_types_pkg::pc_t fetch_pc;
  logic              resolve_valid;
  logic              actual_taken;
  bp_types_pkg::pc_t actual_target;
  logic              pred_taken;
  bp_types_pkg::pc_t pred_next_pc;
  logic              redirect_valid;
  bp_types_pkg::pc_t redirect_pc;

  int          errors = 0;   // Value mismatches seen here
  int          assert_fails;
  logic [31:0] rnd;

  branch_predictor_top DUT (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .resolve_valid  (resolve_valid),
    .actual_taken   (actual_taken),
    .actual_target  (actual_target),
    .pred_taken     (pred_taken),
    .pred_next_pc   (pred_next_pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Checks and drivers
  //////////////////////////////
  task automatic compare_bit(input string name, input logic exp, input logic got);
    assert (got == exp) else begin
      errors = errors + 1;
      $display("Fail %s: expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic compare_pc(input string name, input bp_types_pkg::pc_t exp,
                            input bp_types_pkg::pc_t got);
    assert (got == exp) else begin
      errors = errors + 1;
      $display("Fail %s: expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  // Lookup only with the record left alone
  task automatic check_lookup(input bp_types_pkg::pc_t pc, input logic exp_taken,
                              input bp_types_pkg::pc_t exp_next);
    @(posedge clk);
    fetch_valid   <= 1'b0;
    fetch_pc      <= pc;
    resolve_valid <= 1'b0;
    @(negedge clk);                                          // Outputs settled
    compare_bit("pred_taken", exp_taken, pred_taken);
    compare_pc("pred_next_pc", exp_next, pred_next_pc);
  endtask

  // Fetch one branch, resolve it the next cycle and check the redirect
  task automatic run_branch(input bp_types_pkg::pc_t pc, input logic taken,
                            input bp_types_pkg::pc_t target, input logic exp_redirect);
    bp_types_pkg::pc_t exp_pc;
    exp_pc = taken ? target : pc + 16'd2;
    @(posedge clk);
    fetch_valid   <= 1'b1;
    fetch_pc      <= pc;
    resolve_valid <= 1'b0;
    @(posedge clk);
    fetch_valid   <= 1'b0;
    resolve_valid <= 1'b1;
    actual_taken  <= taken;
    actual_target <= target;
    @(negedge clk);
    compare_bit("redirect_valid", exp_redirect, redirect_valid);
    if (exp_redirect) begin
      compare_pc("redirect_pc", exp_pc, redirect_pc);
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    void'($urandom(32'h85c5_238b));
    rst           = 1'b1;
    fetch_valid   = 1'b0;
    fetch_pc      = '0;
    resolve_valid = 1'b1;                                   // Stale resolve across reset
    actual_taken  = 1'b1;                                   // must not raise a redirect
    actual_target = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    check_lookup(16'h0100, 1'b0, 16'h0102);                 // Empty tables fall through
    check_lookup(PC_A, 1'b0, 16'h1236);
    check_lookup(16'hFFFE, 1'b0, 16'h0000);                 // Fall-through wraps

    run_branch(PC_A, 1'b1, TGT_1, 1'b1);                    // Miss trains up to weak_nt
    check_lookup(PC_A, 1'b0, 16'h1236);
    run_branch(PC_A, 1'b1, TGT_1, 1'b1);                    // Now weak_t
    check_lookup(PC_A, 1'b1, TGT_1);
    run_branch(PC_A, 1'b1, TGT_1, 1'b0);                    // Correct and up to strong_t

    run_branch(PC_A, 1'b0, 16'h0000, 1'b1);                 // Down to weak_t
    check_lookup(PC_A, 1'b1, TGT_1);                        // One miss keeps taken
    run_branch(PC_A, 1'b0, 16'h0000, 1'b1);                 // Down to weak_nt
    check_lookup(PC_A, 1'b0, 16'h1236);

    run_branch(PC_A, 1'b1, TGT_1, 1'b1);
    run_branch(PC_A, 1'b1, TGT_1, 1'b0);                    // Back to strong_t
    check_lookup(PC_A, 1'b1, TGT_1);
    check_lookup(PC_B, 1'b0, 16'h5676);                     // Alias misses on tag
    run_branch(PC_B, 1'b0, 16'h0000, 1'b0);                 // B takes over the BHT row
    check_lookup(PC_A, 1'b0, 16'h1236);
    check_lookup(PC_B, 1'b0, 16'h5676);

    run_branch(PC_A, 1'b1, TGT_1, 1'b1);
    run_branch(PC_A, 1'b1, TGT_1, 1'b1);                    // weak_t again
    check_lookup(PC_A, 1'b1, TGT_1);
    run_branch(PC_A, 1'b1, TGT_2, 1'b1);                    // New target redirects once
    check_lookup(PC_A, 1'b1, TGT_2);
    run_branch(PC_A, 1'b1, TGT_2, 1'b0);

    // Small PC and target pools so hits, aliases and flushes all happen
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd = $urandom;
      @(posedge clk);
      fetch_valid   <= 1'b1;
      fetch_pc      <= {10'h000, rnd[5:1], 1'b0};
      resolve_valid <= 1'b0;
      @(posedge clk);
      fetch_valid   <= rnd[15];                             // Overlaps fetch with resolve
      fetch_pc      <= {10'h000, rnd[21:17], 1'b0};
      resolve_valid <= (rnd[14:13] != 2'b00);
      actual_taken  <= rnd[12];
      actual_target <= {12'h400, 1'b0, rnd[9:8], 1'b0};
    end

    @(posedge clk);
    fetch_valid   <= 1'b0;
    resolve_valid <= 1'b0;
    repeat (3) @(posedge clk);

    assert_fails = DUT.u_assert.reset_redirect_fails + DUT.u_assert.reset_lookup_fails
                 + DUT.u_assert.redirect_match_fails + DUT.u_assert.redirect_pc_fails;
    $display("Summary: %0d value errors, %0d assertion failures", errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
